/* demodMonitor.f */
hdl/demodPkg.sv
hdl/demodRegs.sv
hdl/sampleAlign.sv
hdl/magnitudeTracker.sv
hdl/falseLockDetector.sv
hdl/dacMonitorMux.sv
hdl/demodMonitor.sv
verification/demodMonitor_asserts.sv
verification/demodMonitorTb.sv

/* hdl/dacMonitorMux.sv */
`default_nettype none

module dacMonitorMux (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [3:0]             dacSelect,
    input  demodPkg::monitorTaps_t taps,
    output demodPkg::dacOut_t      dacOut
);
    import demodPkg::*;

    logic [SampleWidth-1:0] selData;
    logic                   selSync;

    // each tap travels with the strobe that qualifies it
    always_comb begin
        case (dacSelect)
            DacQ: begin
                selData = taps.q;
                selSync = taps.swapEn;
            end
            DacFreq: begin
                selData = {taps.freq, {(SampleWidth-AngleWidth){1'b0}}};
                selSync = taps.demodEn;
            end
            DacPhase: begin
                selData = {taps.phase, {(SampleWidth-AngleWidth){1'b0}}};
                selSync = taps.demodEn;
            end
            DacMag: begin
                selData = taps.magLevel;
                selSync = taps.demodEn;
            end
            DacAvgFreq: begin
                selData = taps.averageFreq;
                selSync = taps.demodEn;
            end
            DacFreqError: begin
                selData = {taps.freqError, {(SampleWidth-AngleWidth){1'b0}}};
                selSync = taps.demodEn;
            end
            default: begin
                selData = taps.i;  // DacI and all unused codes
                selSync = taps.swapEn;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dacOut.sync <= 1'b0;
        end else begin
            dacOut.sync <= selSync;
        end
    end

    always_ff @(posedge clk) begin
        dacOut.data <= selData;
    end

endmodule

`default_nettype wire

/* hdl/demodMonitor.sv */
`default_nettype none

module demodMonitor (
    input  logic                             clk,
    input  logic                             rstN,
    input  demodPkg::busReq_t                bus,
    input  demodPkg::rxTaps_t                rx,
    input  logic                             sampleEn,
    input  logic                             demodEn,
    input  logic                             carrierLock,
    output logic [31:0]                      rdData,
    output demodPkg::dacOut_t                dac0,
    output demodPkg::dacOut_t                dac1,
    output demodPkg::dacOut_t                dac2,
    output logic [demodPkg::SampleWidth-1:0] iEye,
    output logic [demodPkg::SampleWidth-1:0] qEye,
    output logic                             eyeSync,
    output logic [3:0]                       demodMode
);
    import demodPkg::*;

    demodCfg_t              cfg;
    monitorTaps_t           taps;
    logic [SampleWidth-1:0] iSwap;
    logic [SampleWidth-1:0] qSwap;
    logic                   swapEn;
    logic [SampleWidth-1:0] magLevel;
    logic [SampleWidth-1:0] averageFreq;
    logic                   highFreqOffset;

    demodRegs u_regs (
        .clk            (clk),
        .rstN           (rstN),
        .bus            (bus),
        .highFreqOffset (highFreqOffset),
        .carrierLock    (carrierLock),
        .rdData         (rdData),
        .cfg            (cfg)
    );

    sampleAlign u_align (
        .clk      (clk),
        .rstN     (rstN),
        .sampleEn (sampleEn),
        .i        (rx.i),
        .q        (rx.q),
        .swapIq   (cfg.swapIq),
        .iSwap    (iSwap),
        .qSwap    (qSwap),
        .swapEn   (swapEn),
        .iEye     (iEye),
        .qEye     (qEye),
        .eyeSync  (eyeSync)
    );

    magnitudeTracker u_mag (
        .clk      (clk),
        .rstN     (rstN),
        .demodEn  (demodEn),
        .mag      (rx.mag),
        .amTC     (cfg.amTC),
        .magLevel (magLevel)
    );

    falseLockDetector u_fld (
        .clk                (clk),
        .rstN               (rstN),
        .demodEn            (demodEn),
        .freq               (rx.freq),
        .freqError          (rx.freqError),
        .demodMode          (cfg.demodMode),
        .falseLockAlpha     (cfg.falseLockAlpha),
        .falseLockThreshold (cfg.falseLockThreshold),
        .averageFreq        (averageFreq),
        .highFreqOffset     (highFreqOffset)
    );

    // detector products go straight to the monitor taps
    always_comb begin
        taps.i           = iSwap;
        taps.q           = qSwap;
        taps.phase       = rx.phase;
        taps.freq        = rx.freq;
        taps.freqError   = rx.freqError;
        taps.magLevel    = magLevel;
        taps.averageFreq = averageFreq;
        taps.swapEn      = swapEn;
        taps.demodEn     = demodEn;
    end

    dacMonitorMux u_dac0 (
        .clk(clk), .rstN(rstN), .dacSelect(cfg.dac0Select), .taps(taps), .dacOut(dac0)
    );

    dacMonitorMux u_dac1 (
        .clk(clk), .rstN(rstN), .dacSelect(cfg.dac1Select), .taps(taps), .dacOut(dac1)
    );

    dacMonitorMux u_dac2 (
        .clk(clk), .rstN(rstN), .dacSelect(cfg.dac2Select), .taps(taps), .dacOut(dac2)
    );

    assign demodMode = cfg.demodMode;

endmodule

`default_nettype wire

/* hdl/demodPkg.sv */
`default_nettype none

package demodPkg;

    // datapath widths
    localparam int SampleWidth = 18;  // baseband and DAC samples
    localparam int AngleWidth  = 12;  // phase, frequency and frequency error
    localparam int MagWidth    = 13;  // unsigned magnitude
    localparam int AccumWidth  = 40;  // magnitude lag accumulator
    localparam int AddrWidth   = 12;  // host register address

    // host register word offsets
    localparam logic [AddrWidth-1:0] RegMode      = 12'h000;
    localparam logic [AddrWidth-1:0] RegDacSelect = 12'h004;
    localparam logic [AddrWidth-1:0] RegFalseLock = 12'h008;
    localparam logic [AddrWidth-1:0] RegAmTc      = 12'h00C;
    localparam logic [AddrWidth-1:0] RegStatus    = 12'h010;  // read only

    // demodulator modes that matter to the false-lock detector
    localparam logic [3:0] ModeOqpsk  = 4'd2;
    localparam logic [3:0] ModeSoqpsk = 4'd3;

    // DAC monitor select codes, anything else falls back to I
    localparam logic [3:0] DacI         = 4'd0;
    localparam logic [3:0] DacQ         = 4'd1;
    localparam logic [3:0] DacFreq      = 4'd4;
    localparam logic [3:0] DacPhase     = 4'd5;
    localparam logic [3:0] DacMag       = 4'd6;
    localparam logic [3:0] DacAvgFreq   = 4'd10;
    localparam logic [3:0] DacFreqError = 4'd11;

    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [31:0]          wrData;
        logic [3:0]           byteEn;  // one write enable per byte lane
    } busReq_t;

    typedef struct packed {
        logic [SampleWidth-1:0] i;
        logic [SampleWidth-1:0] q;
        logic [AngleWidth-1:0]  phase;
        logic [AngleWidth-1:0]  freq;
        logic [AngleWidth-1:0]  freqError;
        logic [MagWidth-1:0]    mag;
    } rxTaps_t;

    typedef struct packed {
        logic [3:0]  demodMode;
        logic        swapIq;
        logic [3:0]  dac0Select;
        logic [3:0]  dac1Select;
        logic [3:0]  dac2Select;
        logic [15:0] falseLockAlpha;
        logic [15:0] falseLockThreshold;
        logic [4:0]  amTC;
    } demodCfg_t;

    typedef struct packed {
        logic [SampleWidth-1:0] i;          // after the swap stage
        logic [SampleWidth-1:0] q;
        logic [AngleWidth-1:0]  phase;
        logic [AngleWidth-1:0]  freq;
        logic [AngleWidth-1:0]  freqError;
        logic [SampleWidth-1:0] magLevel;   // offset binary
        logic [SampleWidth-1:0] averageFreq;
        logic                   swapEn;
        logic                   demodEn;
    } monitorTaps_t;

    typedef struct packed {
        logic                   sync;
        logic [SampleWidth-1:0] data;
    } dacOut_t;

endpackage

`default_nettype wire

/* hdl/demodRegs.sv */
`default_nettype none

module demodRegs (
    input  logic                       clk,
    input  logic                       rstN,
    input  demodPkg::busReq_t          bus,
    input  logic                       highFreqOffset,
    input  logic                       carrierLock,
    output logic [31:0]                rdData,
    output demodPkg::demodCfg_t        cfg
);
    import demodPkg::*;

    // every lane whose byteEn bit is high is written, there is no separate strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfg <= '0;
        end else begin
            case (bus.addr)
                RegMode: begin
                    if (bus.byteEn[0]) begin
                        cfg.demodMode <= bus.wrData[3:0];
                        cfg.swapIq    <= bus.wrData[4];
                    end
                end
                RegDacSelect: begin
                    if (bus.byteEn[0]) begin
                        cfg.dac0Select <= bus.wrData[3:0];
                        cfg.dac1Select <= bus.wrData[7:4];
                    end
                    if (bus.byteEn[1]) begin
                        cfg.dac2Select <= bus.wrData[11:8];
                    end
                end
                RegFalseLock: begin
                    if (bus.byteEn[0]) begin
                        cfg.falseLockAlpha[7:0] <= bus.wrData[7:0];
                    end
                    if (bus.byteEn[1]) begin
                        cfg.falseLockAlpha[15:8] <= bus.wrData[15:8];
                    end
                    if (bus.byteEn[2]) begin
                        cfg.falseLockThreshold[7:0] <= bus.wrData[23:16];
                    end
                    if (bus.byteEn[3]) begin
                        cfg.falseLockThreshold[15:8] <= bus.wrData[31:24];
                    end
                end
                RegAmTc: begin
                    if (bus.byteEn[0]) begin
                        cfg.amTC <= bus.wrData[4:0];
                    end
                end
                default: begin
                    // the status word and unmapped offsets take no writes
                end
            endcase
        end
    end

    // readback is decoded straight from the address with no wait state
    always_comb begin
        rdData = '0;
        case (bus.addr)
            RegMode: begin
                rdData[4:0] = {cfg.swapIq, cfg.demodMode};
            end
            RegDacSelect: begin
                rdData[11:0] = {cfg.dac2Select, cfg.dac1Select, cfg.dac0Select};
            end
            RegFalseLock: begin
                rdData = {cfg.falseLockThreshold, cfg.falseLockAlpha};
            end
            RegAmTc: begin
                rdData[4:0] = cfg.amTC;
            end
            RegStatus: begin
                rdData[1:0] = {carrierLock, highFreqOffset};  // live status bits
            end
            default: begin
                rdData = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/falseLockDetector.sv */
`default_nettype none

module falseLockDetector (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             demodEn,
    input  logic [demodPkg::AngleWidth-1:0]  freq,
    input  logic [demodPkg::AngleWidth-1:0]  freqError,
    input  logic [3:0]                       demodMode,
    input  logic [15:0]                      falseLockAlpha,
    input  logic [15:0]                      falseLockThreshold,
    output logic [demodPkg::SampleWidth-1:0] averageFreq,
    output logic                             highFreqOffset
);
    import demodPkg::*;

    logic [SampleWidth-1:0]          freqSample;
    logic [SampleWidth-1:0]          alphaGain;
    logic [SampleWidth-1:0]          betaGain;
    logic signed [2*SampleWidth-1:0] alphaProd;
    logic signed [2*SampleWidth-1:0] betaProd;
    logic [2*SampleWidth-1:0]        productSum;
    logic [SampleWidth-1:0]          absAverage;
    logic                            offsetMode;

    // offset QPSK modes watch raw frequency, the rest watch frequency error
    assign offsetMode = (demodMode == ModeOqpsk) || (demodMode == ModeSoqpsk);

    // unity gain sits at 2^17 so beta is the complement of alpha
    assign alphaGain = {falseLockAlpha, 2'b00};
    assign betaGain  = {2'b10, 16'h0000} - alphaGain;

    // both multipliers are signed 18x18 and register every clock
    always_ff @(posedge clk) begin
        if (!rstN) begin
            alphaProd <= '0;
            betaProd  <= '0;
        end else begin
            alphaProd <= $signed(freqSample) * $signed(alphaGain);
            betaProd  <= $signed(averageFreq) * $signed(betaGain);
        end
    end

    assign productSum = alphaProd + betaProd;

    assign absAverage = averageFreq[SampleWidth-1] ? -averageFreq : averageFreq;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            freqSample     <= '0;
            averageFreq    <= '0;
            highFreqOffset <= 1'b0;
        end else if (demodEn) begin
            if (offsetMode) begin
                freqSample <= {freq, {(SampleWidth-AngleWidth){1'b0}}};
            end else begin
                freqSample <= {freqError, {(SampleWidth-AngleWidth){1'b0}}};
            end
            // drop the unity scaling of the gains
            averageFreq    <= productSum[2*SampleWidth-2 -: SampleWidth];
            highFreqOffset <= absAverage > {2'b00, falseLockThreshold};
        end
    end

endmodule

`default_nettype wire

/* hdl/magnitudeTracker.sv */
`default_nettype none

module magnitudeTracker (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             demodEn,
    input  logic [demodPkg::MagWidth-1:0]    mag,
    input  logic [4:0]                       amTC,
    output logic [demodPkg::SampleWidth-1:0] magLevel
);
    import demodPkg::*;

    logic [MagWidth:0]     magError;  // two's complement loop error
    logic [MagWidth+1:0]   magDiff;
    logic [AccumWidth-1:0] magAccum;
    logic [AccumWidth-1:0] errExt;

    // the loop compares the input against the top of the accumulator
    assign magDiff = {2'b00, mag} - magAccum[AccumWidth-1 -: MagWidth+2];

    assign errExt = {{(AccumWidth-MagWidth-1){magError[MagWidth]}}, magError};

    // first-order lag loop where a larger amTC gives a faster response
    always_ff @(posedge clk) begin
        if (!rstN) begin
            magError <= '0;
            magAccum <= '0;
        end else if (demodEn) begin
            magError <= magDiff[MagWidth:0];
            magAccum <= magAccum + (errExt << amTC);  // integrates the previous error
        end
    end

    // flip the top bit so the DAC sees offset binary
    assign magLevel = {~magAccum[AccumWidth-2], magAccum[AccumWidth-3 -: SampleWidth-1]};

endmodule

`default_nettype wire

/* hdl/sampleAlign.sv */
`default_nettype none

module sampleAlign (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             sampleEn,
    input  logic [demodPkg::SampleWidth-1:0] i,
    input  logic [demodPkg::SampleWidth-1:0] q,
    input  logic                             swapIq,
    output logic [demodPkg::SampleWidth-1:0] iSwap,
    output logic [demodPkg::SampleWidth-1:0] qSwap,
    output logic                             swapEn,
    output logic [demodPkg::SampleWidth-1:0] iEye,
    output logic [demodPkg::SampleWidth-1:0] qEye,
    output logic                             eyeSync
);
    import demodPkg::*;

    logic [2:0][SampleWidth-1:0] iDly;
    logic [2:0][SampleWidth-1:0] qDly;
    logic [2:0]                  syncDly;

    // swap stage, the pair is crossed when the host asks for it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            iSwap  <= '0;
            qSwap  <= '0;
            swapEn <= 1'b0;
        end else begin
            swapEn <= sampleEn;
            if (sampleEn) begin
                iSwap <= swapIq ? q : i;
                qSwap <= swapIq ? i : q;
            end
        end
    end

    // the eye delay line runs every clock so it matches the downstream sample offset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            iDly    <= '0;
            qDly    <= '0;
            syncDly <= '0;
        end else begin
            iDly    <= {iDly[1:0], iSwap};
            qDly    <= {qDly[1:0], qSwap};
            syncDly <= {syncDly[1:0], swapEn};
        end
    end

    assign iEye    = iDly[2];
    assign qEye    = qDly[2];
    assign eyeSync = syncDly[2];  // sampleEn four clocks later

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the demodMonitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module demodMonitorTb -f demodMonitor.f -o simv

# the log decides the verdict, so a nonzero simulator exit is tolerated here
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

/* verification/demodMonitorTb.sv */
`default_nettype none

module demodMonitorTb;
    timeunit 1ns;
    timeprecision 100ps;
    import demodPkg::*;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 10;
    localparam int RegCycles   = 400;
    localparam int SwapSteps   = 20;  // 16 cycles each
    localparam int DacSteps    = 16;  // 12 cycles each
    localparam int MagRuns     = 4;
    localparam int MagCycles   = 160;
    localparam int LockRuns    = 4;
    localparam int LockCycles  = 200;
    localparam int TotalCycles = ResetCycles + RegCycles + SwapSteps * 16 + DacSteps * 12
                               + MagRuns * (MagCycles + 2) + LockRuns * (LockCycles + 3) + 8;

    logic clk = 1'b0;
    logic rstN;
    busReq_t bus;
    rxTaps_t rx;
    logic sampleEn;
    logic demodEn;
    logic carrierLock;
    logic [31:0] rdData;
    dacOut_t dac0;
    dacOut_t dac1;
    dacOut_t dac2;
    logic [SampleWidth-1:0] iEye;
    logic [SampleWidth-1:0] qEye;
    logic eyeSync;
    logic [3:0] demodMode;

    logic [31:0] lfsr;
    int demodGap;
    logic checkOn;
    int errorCount;
    string testName;

    // reference model state
    logic [4:0]  mMode;
    logic [11:0] mDac;
    logic [31:0] mFl;
    logic [4:0]  mAm;
    logic [17:0] mI;
    logic [17:0] mQ;
    logic        mSwapEn;
    logic [2:0][17:0] eyeI;
    logic [2:0][17:0] eyeQ;
    logic [2:0]  eyeS;
    logic [13:0] mErr;
    logic [39:0] mAcc;
    logic [17:0] mFs;
    logic [17:0] mAvg;
    logic        mHfo;
    logic signed [35:0] mProdA;
    logic signed [35:0] mProdB;
    logic [2:0][18:0] mDacOut;  // {sync, data} per channel

    logic [17:0] alphaGain;
    logic [17:0] betaGain;
    logic [17:0] absAvg;
    logic [14:0] magDiff;
    logic [35:0] prodSum;

    demodMonitor u_dut (
        .clk(clk), .rstN(rstN), .bus(bus), .rx(rx), .sampleEn(sampleEn), .demodEn(demodEn),
        .carrierLock(carrierLock), .rdData(rdData), .dac0(dac0), .dac1(dac1), .dac2(dac2),
        .iEye(iEye), .qEye(qEye), .eyeSync(eyeSync), .demodMode(demodMode)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // alpha is scaled by four so that unity weight sits at 2^17
    assign alphaGain = {mFl[15:0], 2'b00};
    assign betaGain  = 18'h20000 - alphaGain;
    assign absAvg    = mAvg[17] ? 18'(-mAvg) : mAvg;
    assign magDiff   = {2'b00, rx.mag} - mAcc[39:25];
    assign prodSum   = mProdA + mProdB;

    function automatic logic [31:0] rnd(input int bits);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int k = 0; k < bits; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32, 22, 2, 1
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] laneWrite(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be, input logic [31:0] regMask);
        logic [31:0] m;
        m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}} & regMask;
        return (old & ~m) | (data & m);
    endfunction

    function automatic logic [18:0] selectTap(input logic [3:0] code);
        case (code)
            DacQ:         return {mSwapEn, mQ};
            DacFreq:      return {demodEn, rx.freq, 6'b0};
            DacPhase:     return {demodEn, rx.phase, 6'b0};
            DacMag:       return {demodEn, ~mAcc[38], mAcc[37:21]};
            DacAvgFreq:   return {demodEn, mAvg};
            DacFreqError: return {demodEn, rx.freqError, 6'b0};
            default:      return {mSwapEn, mI};  // unused codes act as I
        endcase
    endfunction

    function automatic logic [31:0] readModel(input logic [11:0] addr);
        case (addr)
            RegMode:      return {27'b0, mMode};
            RegDacSelect: return {20'b0, mDac};
            RegFalseLock: return mFl;
            RegAmTc:      return {27'b0, mAm};
            RegStatus:    return {30'b0, carrierLock, mHfo};
            default:      return 32'b0;
        endcase
    endfunction

    always @(posedge clk) begin
        mDacOut[0] <= selectTap(mDac[3:0]);
        mDacOut[1] <= selectTap(mDac[7:4]);
        mDacOut[2] <= selectTap(mDac[11:8]);
        if (!rstN) begin
            mMode <= '0;
            mDac <= '0;
            mFl <= '0;
            mAm <= '0;
            mI <= '0;
            mQ <= '0;
            mSwapEn <= 1'b0;
            eyeI <= '0;
            eyeQ <= '0;
            eyeS <= '0;
            mErr <= '0;
            mAcc <= '0;
            mFs <= '0;
            mAvg <= '0;
            mHfo <= 1'b0;
            mProdA <= '0;
            mProdB <= '0;
        end else begin
            case (bus.addr)
                RegMode:      mMode <= 5'(laneWrite({27'b0, mMode}, bus.wrData, bus.byteEn, 32'h1f));
                RegDacSelect: mDac <= 12'(laneWrite({20'b0, mDac}, bus.wrData, bus.byteEn, 32'hfff));
                RegFalseLock: mFl <= laneWrite(mFl, bus.wrData, bus.byteEn, 32'hffff_ffff);
                RegAmTc:      mAm <= 5'(laneWrite({27'b0, mAm}, bus.wrData, bus.byteEn, 32'h1f));
                default:      ;
            endcase
            mSwapEn <= sampleEn;
            if (sampleEn) begin
                mI <= mMode[4] ? rx.q : rx.i;
                mQ <= mMode[4] ? rx.i : rx.q;
            end
            eyeI <= {eyeI[1:0], mI};
            eyeQ <= {eyeQ[1:0], mQ};
            eyeS <= {eyeS[1:0], mSwapEn};
            mProdA <= $signed(mFs) * $signed(alphaGain);
            mProdB <= $signed(mAvg) * $signed(betaGain);
            if (demodEn) begin
                mErr <= magDiff[13:0];
                mAcc <= mAcc + ({{26{mErr[13]}}, mErr} << mAm);
                mFs <= (mMode[3:0] == ModeOqpsk || mMode[3:0] == ModeSoqpsk) ?
                       {rx.freq, 6'b0} : {rx.freqError, 6'b0};
                mAvg <= prodSum[34:17];
                mHfo <= absAvg > {2'b00, mFl[31:16]};
            end
        end
    end

    task automatic check(input string sig, input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("MISMATCH %s/%s expected %h actual %h", testName, sig, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (checkOn) begin
            check("rdData", 64'(readModel(bus.addr)), 64'(rdData));
            check("eye", 64'({eyeS[2], eyeI[2], eyeQ[2]}), 64'({eyeSync, iEye, qEye}));
            check("dac0", 64'(mDacOut[0]), 64'({dac0.sync, dac0.data}));
            check("dac1", 64'(mDacOut[1]), 64'({dac1.sync, dac1.data}));
            check("dac2", 64'(mDacOut[2]), 64'({dac2.sync, dac2.data}));
            check("demodMode", 64'(mMode[3:0]), 64'(demodMode));
        end
    end

    task automatic driveCycle(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        logic strobe;
        @(posedge clk);
        strobe = (demodGap >= 3) && (rnd(1) != 0);  // keeps demodEn four cycles apart
        demodGap = strobe ? 0 : demodGap + 1;
        bus <= '{addr: addr, wrData: data, byteEn: be};
        rx <= '{i: 18'(rnd(18)), q: 18'(rnd(18)), phase: 12'(rnd(12)), freq: 12'(rnd(12)),
                freqError: 12'(rnd(12)), mag: 13'(rnd(13))};
        sampleEn <= rnd(1) != 0;
        demodEn <= strobe;
        carrierLock <= rnd(1) != 0;
    endtask

    function automatic logic [11:0] randomAddr();
        logic [2:0] pick;
        pick = 3'(rnd(3));
        case (pick)
            3'd0:    return RegMode;
            3'd1:    return RegDacSelect;
            3'd2:    return RegFalseLock;
            3'd3:    return RegAmTc;
            3'd4:    return RegStatus;
            default: return 12'(rnd(12));
        endcase
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) driveCycle(randomAddr(), rnd(32), 4'h0);
    endtask

    task automatic idleAt(input int n, input logic [11:0] addr);
        repeat (n) driveCycle(addr, rnd(32), 4'h0);
    endtask

    initial begin
        rstN = 1'b0;
        bus = '0;
        rx = '0;
        sampleEn = 1'b0;
        demodEn = 1'b0;
        carrierLock = 1'b0;
        lfsr = 32'hb65a_c7e7;
        demodGap = 0;
        checkOn = 1'b0;
        errorCount = 0;
        testName = "reset";
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        checkOn <= 1'b1;

        testName = "registers";
        repeat (RegCycles) driveCycle(randomAddr(), rnd(32), 4'(rnd(4)));

        testName = "swapEye";
        for (int k = 0; k < SwapSteps; k++) begin
            driveCycle(RegMode, {27'b0, k[0], 4'd0}, 4'h1);
            idleCycles(15);
        end

        testName = "dacSelect";
        for (int c = 0; c < DacSteps; c++) begin
            driveCycle(RegDacSelect, {20'b0, 4'(c), 4'(c), 4'(c)}, 4'h3);
            idleCycles(11);
        end

        testName = "magnitude";
        for (int k = 0; k < MagRuns; k++) begin
            driveCycle(RegDacSelect, {20'b0, DacAvgFreq, DacQ, DacMag}, 4'h3);
            driveCycle(RegAmTc, 32'(k * 5), 4'h1);
            idleCycles(MagCycles);
        end

        testName = "falseLock";
        for (int k = 0; k < LockRuns; k++) begin
            driveCycle(RegMode, {28'b0, k[0] ? ModeOqpsk : 4'd7}, 4'h1);
            // alpha stays below unity weight so the average is a true average
            driveCycle(RegFalseLock, {2'b00, 14'(rnd(14)), 1'b0, 15'(rnd(15))}, 4'hf);
            driveCycle(RegDacSelect, {20'b0, DacAvgFreq, DacMag, DacAvgFreq}, 4'h3);
            idleAt(LockCycles, RegStatus);  // status bit 0 checked after every strobe
        end

        idleCycles(8);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TotalCycles * ClkPeriod + 1000);
        $display("timeout: the stimulus did not complete in the expected time");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verification/demodMonitor_asserts.sv */
`default_nettype none

module demodMonitor_asserts (
    input logic                clk,
    input logic                rstN,
    input logic                sampleEn,
    input logic                demodEn,
    input logic                swapEn,
    input logic                eyeSync,
    input logic                highFreqOffset,
    input demodPkg::demodCfg_t cfg,
    input demodPkg::dacOut_t   dac0,
    input demodPkg::dacOut_t   dac1,
    input demodPkg::dacOut_t   dac2
);
    timeunit 1ns;
    timeprecision 100ps;
    import demodPkg::*;

    logic       seenDemod;
    logic [2:0] iSel;

    function automatic logic selectsI(input logic [3:0] code);
        return !(code inside {DacQ, DacFreq, DacPhase, DacMag, DacAvgFreq, DacFreqError});
    endfunction

    assign iSel = {selectsI(cfg.dac2Select), selectsI(cfg.dac1Select), selectsI(cfg.dac0Select)};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            seenDemod <= 1'b0;
        end else if (demodEn) begin
            seenDemod <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) eyeSync == $past(sampleEn, 4))
        else $error("eyeSync is not sampleEn delayed four cycles");
    assert property (@(posedge clk) disable iff (!rstN) $past(iSel[0]) |-> dac0.sync == $past(swapEn))
        else $error("dac0 sync does not follow swapEn");
    assert property (@(posedge clk) disable iff (!rstN) $past(iSel[1]) |-> dac1.sync == $past(swapEn))
        else $error("dac1 sync does not follow swapEn");
    assert property (@(posedge clk) disable iff (!rstN) $past(iSel[2]) |-> dac2.sync == $past(swapEn))
        else $error("dac2 sync does not follow swapEn");
    assert property (@(posedge clk) disable iff (!rstN) !seenDemod |-> !highFreqOffset)
        else $error("highFreqOffset rose before any demodEn");

endmodule

bind demodMonitor demodMonitor_asserts u_asserts (
    .clk(clk), .rstN(rstN), .sampleEn(sampleEn), .demodEn(demodEn), .swapEn(swapEn),
    .eyeSync(eyeSync), .highFreqOffset(highFreqOffset), .cfg(cfg),
    .dac0(dac0), .dac1(dac1), .dac2(dac2)
);

`default_nettype wire
